//--- include/keyboardKeys.svh
`ifndef KEYBOARD_KEYS_SVH
`define KEYBOARD_KEYS_SVH

// Bit positions of the named keys in the panel keyboard vector.
// The panel is wired as five rows of eight keys, one row per byte.

// Row 0 holds the machine control keys.
localparam int keyHardRst = 0;
localparam int keySoftRst = 1;
localparam int keyHalt    = 2;
localparam int keyStep    = 3;
localparam int keyRun     = 4;

// Row 1 selects the counter under edit.
localparam int keyIp   = 8;
localparam int keyAp   = 9;
localparam int keyLoop = 10;
localparam int keyData = 11;

// Row 2 holds the increment and decrement keys.
localparam int keyInc = 16;
localparam int keyDec = 17;

// Row 3 is the arrow cluster.
// Up and down move the IP by a row of sixteen cells.
localparam int keyArrowUp    = 24;
localparam int keyArrowDown  = 25;
localparam int keyArrowLeft  = 26;
localparam int keyArrowRight = 27;

// Row 4 carries no named keys yet.

`endif

//--- verilog/dpcPkg.sv
`default_nettype none

package dpcPkg;

    // Width of the panel keyboard vector and of the symbol input.
    localparam int keyCount    = 40;
    localparam int symbolWidth = 8;

    `include "keyboardKeys.svh"

    // Counter currently under edit from the panel.
    typedef enum logic [2:0] {
        selNone = 3'd0,
        selIp   = 3'd1,
        selAp   = 3'd2,
        selLoop = 3'd3,
        selData = 3'd4
    } counterSel_t;

    // Machine state. Both reset states clear the counters.
    typedef enum logic [2:0] {
        dpcHardRst = 3'd0,
        dpcSoftRst = 3'd1,
        dpcHalt    = 3'd2,
        dpcStep    = 3'd3,
        dpcRun     = 3'd4
    } dpcState_t;

endpackage

`default_nettype wire

//--- verilog/keyEdgeDetector.sv
`timescale 1ns/1ps
`default_nettype none

module keyEdgeDetector (
    input  logic                           Clock_1ms,
    input  logic                           Rst_n,
    input  logic [dpcPkg::keyCount-1:0]    keys,
    input  logic [dpcPkg::symbolWidth-1:0] symbol,
    output logic [dpcPkg::keyCount-1:0]    keyRise,
    output logic                           symbolRise
);

    logic [dpcPkg::keyCount-1:0]    keysPrev;
    logic [dpcPkg::symbolWidth-1:0] symbolPrev;

    // Previous levels clear on reset, so a key held through reset
    // still gives one pulse once the machine is out of reset.
    always_ff @(posedge Clock_1ms or negedge Rst_n) begin
        if (!Rst_n) begin
            keysPrev   <= '0;
            symbolPrev <= '0;
        end else begin
            keysPrev   <= keys;
            symbolPrev <= symbol;
        end
    end

    assign keyRise = keys & ~keysPrev;

    // Any symbol bit going high counts as one symbol event.
    assign symbolRise = |(symbol & ~symbolPrev);

endmodule

`default_nettype wire

//--- verilog/counterSelector.sv
`timescale 1ns/1ps
`default_nettype none

module counterSelector (
    input  logic                        Clock_1ms,
    input  logic                        Rst_n,
    input  logic [dpcPkg::keyCount-1:0] keys,
    output dpcPkg::counterSel_t         selected
);

    import dpcPkg::*;

    counterSel_t selectedNext;

    // Select keys act on levels. The key of the current selection is
    // skipped so a lower-priority key can still take over while it is held.
    always_comb begin
        if (keys[keyIp] && (selected != selIp)) begin
            selectedNext = selIp;
        end else if (keys[keyAp] && (selected != selAp)) begin
            selectedNext = selAp;
        end else if (keys[keyLoop] && (selected != selLoop)) begin
            selectedNext = selLoop;
        end else if (keys[keyData] && (selected != selData)) begin
            selectedNext = selData;
        end else begin
            selectedNext = selected;
        end
    end

    always_ff @(posedge Clock_1ms or negedge Rst_n) begin
        if (!Rst_n) begin
            selected <= selNone;
        end else begin
            selected <= selectedNext;
        end
    end

endmodule

`default_nettype wire

//--- verilog/machineStateControl.sv
`timescale 1ns/1ps
`default_nettype none

module machineStateControl (
    input  logic                        Clock_1ms,
    input  logic                        Rst_n,
    input  logic [dpcPkg::keyCount-1:0] keys,
    input  logic [dpcPkg::keyCount-1:0] keyRise,
    output dpcPkg::dpcState_t           state
);

    import dpcPkg::*;

    dpcState_t stateNext;
    logic      stepEdge;

    // Only the step key is edge sensitive, the others act on levels.
    assign stepEdge = keyRise[keyStep];

    // The hard reset state does not look at its own key, only the
    // soft reset key can move it to another reset state.
    always_comb begin
        case (state)
            dpcHardRst: begin
                if (keys[keySoftRst])     stateNext = dpcSoftRst;
                else if (stepEdge)        stateNext = dpcStep;
                else if (keys[keyRun])    stateNext = dpcRun;
                else                      stateNext = dpcHalt;
            end
            dpcSoftRst: begin
                if (keys[keyHardRst])     stateNext = dpcHardRst;
                else if (stepEdge)        stateNext = dpcStep;
                else if (keys[keyRun])    stateNext = dpcRun;
                else                      stateNext = dpcHalt;
            end
            dpcStep: begin
                // A single step lasts one cycle and drops back to halt.
                if (keys[keyHardRst])     stateNext = dpcHardRst;
                else if (keys[keySoftRst]) stateNext = dpcSoftRst;
                else if (keys[keyRun])    stateNext = dpcRun;
                else                      stateNext = dpcHalt;
            end
            dpcRun: begin
                if (keys[keyHardRst])     stateNext = dpcHardRst;
                else if (keys[keySoftRst]) stateNext = dpcSoftRst;
                else if (keys[keyHalt])   stateNext = dpcHalt;
                else if (stepEdge)        stateNext = dpcStep;
                else                      stateNext = dpcRun;
            end
            dpcHalt: begin
                if (keys[keyHardRst])     stateNext = dpcHardRst;
                else if (keys[keySoftRst]) stateNext = dpcSoftRst;
                else if (stepEdge)        stateNext = dpcStep;
                else if (keys[keyRun])    stateNext = dpcRun;
                else                      stateNext = dpcHalt;
            end
            default: begin
                stateNext = dpcHalt;
            end
        endcase
    end

    always_ff @(posedge Clock_1ms or negedge Rst_n) begin
        if (!Rst_n) begin
            state <= dpcHardRst;
        end else begin
            state <= stateNext;
        end
    end

endmodule

`default_nettype wire

//--- verilog/panelCounters.sv
`timescale 1ns/1ps
`default_nettype none

module panelCounters #(
    parameter int IpWidth   = 18,
    parameter int ApWidth   = 15,
    parameter int LoopWidth = 9,
    parameter int DataWidth = 9
) (
    input  logic                        Clock_1ms,
    input  logic                        Rst_n,
    input  dpcPkg::dpcState_t           state,
    input  dpcPkg::counterSel_t         selected,
    input  logic [dpcPkg::keyCount-1:0] keyRise,
    input  logic                        symbolRise,
    output logic [IpWidth-1:0]          ipCounter,
    output logic [ApWidth-1:0]          apCounter,
    output logic [LoopWidth-1:0]        loopCounter,
    output logic [DataWidth-1:0]        dataCounter
);

    import dpcPkg::*;

    // The up and down arrows move the IP by one row of sixteen cells.
    localparam logic [IpWidth-1:0] ipRowStep = IpWidth'(16);

    logic ipSelected;

    assign ipSelected = (selected == selIp);

    // All arithmetic wraps at the width of each counter.
    always_ff @(posedge Clock_1ms or negedge Rst_n) begin
        if (!Rst_n) begin
            ipCounter   <= '0;
            apCounter   <= '0;
            loopCounter <= '0;
            dataCounter <= '0;
        end else begin
            case (state)
                dpcHardRst, dpcSoftRst: begin
                    ipCounter   <= '0;
                    apCounter   <= '0;
                    loopCounter <= '0;
                    dataCounter <= '0;
                end
                dpcStep, dpcRun: begin
                    ipCounter <= ipCounter + 1'b1;
                end
                default: begin
                    // Halt. The first matching edit wins.
                    if (keyRise[keyInc]) begin
                        case (selected)
                            selIp:   ipCounter   <= ipCounter + 1'b1;
                            selAp:   apCounter   <= apCounter + 1'b1;
                            selLoop: loopCounter <= loopCounter + 1'b1;
                            selData: dataCounter <= dataCounter + 1'b1;
                            default: ;
                        endcase
                    end else if (keyRise[keyDec]) begin
                        case (selected)
                            selIp:   ipCounter   <= ipCounter - 1'b1;
                            selAp:   apCounter   <= apCounter - 1'b1;
                            selLoop: loopCounter <= loopCounter - 1'b1;
                            selData: dataCounter <= dataCounter - 1'b1;
                            default: ;
                        endcase
                    end else if (ipSelected && keyRise[keyArrowUp]) begin
                        ipCounter <= ipCounter - ipRowStep;
                    end else if (ipSelected && keyRise[keyArrowDown]) begin
                        ipCounter <= ipCounter + ipRowStep;
                    end else if (ipSelected && keyRise[keyArrowLeft]) begin
                        ipCounter <= ipCounter - 1'b1;
                    end else if (ipSelected && keyRise[keyArrowRight]) begin
                        ipCounter <= ipCounter + 1'b1;
                    end else if (symbolRise) begin
                        // Each typed symbol lands in the next program cell.
                        ipCounter <= ipCounter + 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/nixieScanner.sv
`timescale 1ns/1ps
`default_nettype none

module nixieScanner #(
    parameter int Digits  = 6,
    parameter int IpWidth = 18
) (
    input  logic               Clock_1ms,
    input  logic               Rst_n,
    input  logic [IpWidth-1:0] ipCounter,
    output logic [3:0]         cathode,
    output logic [Digits-1:0]  anode
);

    localparam int IndexWidth = (Digits > 1) ? $clog2(Digits) : 1;
    localparam logic [IndexWidth-1:0] lastIndex = IndexWidth'(Digits - 1);

    logic [IndexWidth-1:0] digitIndex;
    logic [2:0]            octalDigit;

    // Wrapping scan counter, one digit per clock.
    always_ff @(posedge Clock_1ms or negedge Rst_n) begin
        if (!Rst_n) begin
            digitIndex <= '0;
        end else if (digitIndex == lastIndex) begin
            digitIndex <= '0;
        end else begin
            digitIndex <= digitIndex + 1'b1;
        end
    end

    assign anode      = Digits'(1) << digitIndex;
    assign octalDigit = ipCounter[digitIndex * 3 +: 3];

    // IN-12 cathodes are not wired in numeric order on the tube socket.
    always_comb begin
        case (octalDigit)
            3'd0:    cathode = 4'd1;
            3'd1:    cathode = 4'd0;
            3'd2:    cathode = 4'd2;
            3'd3:    cathode = 4'd3;
            3'd4:    cathode = 4'd6;
            3'd5:    cathode = 4'd8;
            3'd6:    cathode = 4'd9;
            default: cathode = 4'd7;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/dekatronPanel.sv
`timescale 1ns/1ps
`default_nettype none

module dekatronPanel #(
    parameter int IpWidth   = 18,
    parameter int ApWidth   = 15,
    parameter int LoopWidth = 9,
    parameter int DataWidth = 9,
    parameter int Digits    = 6
) (
    input  logic                           Clock_1ms,
    input  logic                           Rst_n,
    input  logic [dpcPkg::keyCount-1:0]    keys,
    input  logic [dpcPkg::symbolWidth-1:0] symbol,
    output dpcPkg::dpcState_t              state,
    output dpcPkg::counterSel_t            selected,
    output logic [IpWidth-1:0]             ipCounter,
    output logic [ApWidth-1:0]             apCounter,
    output logic [LoopWidth-1:0]           loopCounter,
    output logic [DataWidth-1:0]           dataCounter,
    output logic [3:0]                     cathode,
    output logic [Digits-1:0]              anode
);

    import dpcPkg::*;

    logic [keyCount-1:0] keyRise;
    logic                symbolRise;

    keyEdgeDetector u_keyEdgeDetector (
        .Clock_1ms  (Clock_1ms),
        .Rst_n      (Rst_n),
        .keys       (keys),
        .symbol     (symbol),
        .keyRise    (keyRise),
        .symbolRise (symbolRise)
    );

    counterSelector u_counterSelector (
        .Clock_1ms (Clock_1ms),
        .Rst_n     (Rst_n),
        .keys      (keys),
        .selected  (selected)
    );

    machineStateControl u_machineStateControl (
        .Clock_1ms (Clock_1ms),
        .Rst_n     (Rst_n),
        .keys      (keys),
        .keyRise   (keyRise),
        .state     (state)
    );

    // The counters see the registered state, so they act one cycle
    // after the key that changed it.
    panelCounters #(
        .IpWidth   (IpWidth),
        .ApWidth   (ApWidth),
        .LoopWidth (LoopWidth),
        .DataWidth (DataWidth)
    ) u_panelCounters (
        .Clock_1ms   (Clock_1ms),
        .Rst_n       (Rst_n),
        .state       (state),
        .selected    (selected),
        .keyRise     (keyRise),
        .symbolRise  (symbolRise),
        .ipCounter   (ipCounter),
        .apCounter   (apCounter),
        .loopCounter (loopCounter),
        .dataCounter (dataCounter)
    );

    nixieScanner #(
        .Digits  (Digits),
        .IpWidth (IpWidth)
    ) u_nixieScanner (
        .Clock_1ms (Clock_1ms),
        .Rst_n     (Rst_n),
        .ipCounter (ipCounter),
        .cathode   (cathode),
        .anode     (anode)
    );

endmodule

`default_nettype wire

//--- include/panelRefModel.svh
`ifndef PANEL_REF_MODEL_SVH
`define PANEL_REF_MODEL_SVH

// Cycle model of the front panel, stepped once per rising clock edge.
// Counters act on the state and selection held before the edge.

logic [keyCount-1:0]    mKeysPrev;
logic [symbolWidth-1:0] mSymbolPrev;
counterSel_t            mSel;
dpcState_t              mState;
logic [IpWidth-1:0]     mIp;
logic [ApWidth-1:0]     mAp;
logic [LoopWidth-1:0]   mLoop;
logic [DataWidth-1:0]   mData;
int                     mScan;

task automatic clearCounters();
    mIp   = '0;
    mAp   = '0;
    mLoop = '0;
    mData = '0;
endtask

task automatic clearModel();
    mKeysPrev   = '0;
    mSymbolPrev = '0;
    mSel        = selNone;
    mState      = dpcHardRst;
    mScan       = 0;
    clearCounters();
endtask

// IN-12 socket pin for each octal digit.
function automatic logic [3:0] pinForDigit(input logic [2:0] digit);
    case (digit)
        3'd0:    return 4'd1;
        3'd1:    return 4'd0;
        3'd2:    return 4'd2;
        3'd3:    return 4'd3;
        3'd4:    return 4'd6;
        3'd5:    return 4'd8;
        3'd6:    return 4'd9;
        default: return 4'd7;
    endcase
endfunction

function automatic dpcState_t nextMachineState(input dpcState_t cur,
                                               input logic [keyCount-1:0] lvl,
                                               input logic stepEdge);
    dpcState_t nxt;
    nxt = dpcHalt;
    case (cur)
        dpcHardRst: begin
            if (lvl[keySoftRst]) nxt = dpcSoftRst;
            else if (stepEdge) nxt = dpcStep;
            else if (lvl[keyRun]) nxt = dpcRun;
        end
        dpcSoftRst: begin
            if (lvl[keyHardRst]) nxt = dpcHardRst;
            else if (stepEdge) nxt = dpcStep;
            else if (lvl[keyRun]) nxt = dpcRun;
        end
        dpcStep: begin
            if (lvl[keyHardRst]) nxt = dpcHardRst;
            else if (lvl[keySoftRst]) nxt = dpcSoftRst;
            else if (lvl[keyRun]) nxt = dpcRun;
        end
        dpcRun: begin
            if (lvl[keyHardRst]) nxt = dpcHardRst;
            else if (lvl[keySoftRst]) nxt = dpcSoftRst;
            else if (lvl[keyHalt]) nxt = dpcHalt;
            else if (stepEdge) nxt = dpcStep;
            else nxt = dpcRun;
        end
        default: begin
            if (lvl[keyHardRst]) nxt = dpcHardRst;
            else if (lvl[keySoftRst]) nxt = dpcSoftRst;
            else if (stepEdge) nxt = dpcStep;
            else if (lvl[keyRun]) nxt = dpcRun;
        end
    endcase
    return nxt;
endfunction

task automatic adjustSelected(input bit up);
    case (mSel)
        selIp:   mIp   = up ? mIp + 1'b1 : mIp - 1'b1;
        selAp:   mAp   = up ? mAp + 1'b1 : mAp - 1'b1;
        selLoop: mLoop = up ? mLoop + 1'b1 : mLoop - 1'b1;
        selData: mData = up ? mData + 1'b1 : mData - 1'b1;
        default: ;
    endcase
endtask

task automatic stepModel(input logic [keyCount-1:0] lvl, input logic [symbolWidth-1:0] sym);
    logic [keyCount-1:0] rise;
    logic                symRise;
    logic                ipSel;
    dpcState_t           stateNext;
    counterSel_t         selNext;
    rise      = lvl & ~mKeysPrev;
    symRise   = |(sym & ~mSymbolPrev);
    ipSel     = (mSel == selIp);
    stateNext = nextMachineState(mState, lvl, rise[keyStep]);
    selNext   = mSel;
    if (lvl[keyIp] && mSel != selIp) selNext = selIp;
    else if (lvl[keyAp] && mSel != selAp) selNext = selAp;
    else if (lvl[keyLoop] && mSel != selLoop) selNext = selLoop;
    else if (lvl[keyData] && mSel != selData) selNext = selData;
    case (mState)
        dpcHardRst, dpcSoftRst: clearCounters();
        dpcStep, dpcRun:        mIp = mIp + 1'b1;
        default: begin
            if (rise[keyInc]) adjustSelected(1'b1);
            else if (rise[keyDec]) adjustSelected(1'b0);
            else if (ipSel && rise[keyArrowUp]) mIp = mIp - IpWidth'(16);
            else if (ipSel && rise[keyArrowDown]) mIp = mIp + IpWidth'(16);
            else if (ipSel && rise[keyArrowLeft]) mIp = mIp - 1'b1;
            else if (ipSel && rise[keyArrowRight]) mIp = mIp + 1'b1;
            else if (symRise) mIp = mIp + 1'b1;
        end
    endcase
    mState      = stateNext;
    mSel        = selNext;
    mKeysPrev   = lvl;
    mSymbolPrev = sym;
    mScan       = (mScan == Digits - 1) ? 0 : mScan + 1;
endtask

`endif

//--- verif/dekatronPanelTb.sv
`timescale 1ns/1ps
`default_nettype none

module dekatronPanelTb;

    import dpcPkg::*;

    localparam int IpWidth       = 18;
    localparam int ApWidth       = 15;
    localparam int LoopWidth     = 9;
    localparam int DataWidth     = 9;
    localparam int Digits        = 6;
    localparam int runCycles     = 4000;
    localparam int settleTimeout = 8;

    logic                   Clock_1ms;
    logic                   Rst_n;
    logic [keyCount-1:0]    keys;
    logic [symbolWidth-1:0] symbol;
    dpcState_t              state;
    counterSel_t            selected;
    logic [IpWidth-1:0]     ipCounter;
    logic [ApWidth-1:0]     apCounter;
    logic [LoopWidth-1:0]   loopCounter;
    logic [DataWidth-1:0]   dataCounter;
    logic [3:0]             cathode;
    logic [Digits-1:0]      anode;

    // Remaining cycles each key stays pressed.
    int holdLeft [keyCount];

    `include "panelRefModel.svh"

    dekatronPanel #(
        .IpWidth   (IpWidth),
        .ApWidth   (ApWidth),
        .LoopWidth (LoopWidth),
        .DataWidth (DataWidth),
        .Digits    (Digits)
    ) u_dekatronPanel (
        .Clock_1ms   (Clock_1ms),
        .Rst_n       (Rst_n),
        .keys        (keys),
        .symbol      (symbol),
        .state       (state),
        .selected    (selected),
        .ipCounter   (ipCounter),
        .apCounter   (apCounter),
        .loopCounter (loopCounter),
        .dataCounter (dataCounter),
        .cathode     (cathode),
        .anode       (anode)
    );

    initial begin
        Clock_1ms = 1'b0;
        forever #50 Clock_1ms = ~Clock_1ms;
    end

    task automatic stopOnFailure(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            stopOnFailure($sformatf("Mismatch at %0t: %s is %0h, expected %0h",
                                    $time, name, actual, expected));
        end
    endtask

    task automatic compareOutputs();
        checkValue("state", 32'(state), 32'(mState));
        checkValue("selected", 32'(selected), 32'(mSel));
        checkValue("ipCounter", 32'(ipCounter), 32'(mIp));
        checkValue("apCounter", 32'(apCounter), 32'(mAp));
        checkValue("loopCounter", 32'(loopCounter), 32'(mLoop));
        checkValue("dataCounter", 32'(dataCounter), 32'(mData));
        checkValue("anode", 32'(anode), 32'(1) << mScan);
        checkValue("cathode", 32'(cathode), 32'(pinForDigit(3'(mIp >> (3 * mScan)))));
    endtask

    // Reset keys are pressed rarely so that runs and edits get time to happen.
    task automatic driveRandomInputs();
        int          k;
        int unsigned chance;
        for (k = 0; k < keyCount; k++) begin
            chance = (k == keyHardRst || k == keySoftRst) ? 400 : 20;
            if (holdLeft[k] > 0) holdLeft[k]--;
            else if (($urandom % chance) == 0) holdLeft[k] = $urandom_range(4, 1);
            keys[k] = (holdLeft[k] > 0);
        end
        symbol = (($urandom % 6) == 0) ? 8'($urandom) : 8'h00;
    endtask

    task automatic runCycle(input bit randomInputs);
        @(posedge Clock_1ms);
        stepModel(keys, symbol);
        #5;
        compareOutputs();
        if (randomInputs) driveRandomInputs();
    endtask

    task automatic waitForHalt(input string phase);
        int cycles;
        cycles = 0;
        while (state != dpcHalt) begin
            if (cycles == settleTimeout) begin
                stopOnFailure($sformatf("Timeout: machine did not reach halt %s within %0d cycles.",
                                        phase, settleTimeout));
            end else begin
                runCycle(1'b0);
                cycles++;
            end
        end
    endtask

    initial begin
        int k;
        Rst_n  = 1'b0;
        keys   = '0;
        symbol = '0;
        for (k = 0; k < keyCount; k++) holdLeft[k] = 0;
        void'($urandom(32'h09b3_1cb8));
        clearModel();
        repeat (16) @(posedge Clock_1ms);
        #5;
        Rst_n = 1'b1;
        checkValue("state", 32'(state), 32'(dpcHardRst));
        checkValue("selected", 32'(selected), 32'(selNone));
        checkValue("ipCounter", 32'(ipCounter), 32'd0);
        checkValue("apCounter", 32'(apCounter), 32'd0);
        checkValue("loopCounter", 32'(loopCounter), 32'd0);
        checkValue("dataCounter", 32'(dataCounter), 32'd0);
        checkValue("anode", 32'(anode), 32'd1);
        waitForHalt("after reset");
        repeat (runCycles) runCycle(1'b1);
        // Hold only the halt key so the machine settles from any state.
        keys          = '0;
        keys[keyHalt] = 1'b1;
        symbol        = '0;
        waitForHalt("at the end of the run");
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
+incdir+include
verilog/dpcPkg.sv
verilog/keyEdgeDetector.sv
verilog/counterSelector.sv
verilog/machineStateControl.sv
verilog/panelCounters.sv
verilog/nixieScanner.sv
verilog/dekatronPanel.sv
verif/dekatronPanelTb.sv

//--- run.sh
#!/bin/sh
# Build and run the panel testbench; the exit status is the result.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -sv --top-module dekatronPanelTb \
    -f compile.f -Mdir obj_dir \
    && ./obj_dir/VdekatronPanelTb \
    || exit 1
